// ==== rtl/dds_pkg.sv ====
`default_nettype none

package dds_pkg;

  ////////////////////////////////////////////////////////////
  // phase path
  ////////////////////////////////////////////////////////////

  localparam int PHASE_BITS = 16;
  localparam int QUANT_BITS = 6;
  localparam int LUT_ADDR_BITS = PHASE_BITS - QUANT_BITS;
  localparam int LUT_DEPTH = 2 ** LUT_ADDR_BITS;
  localparam int LANES = 4;                           // samples carried in one output word

  ////////////////////////////////////////////////////////////
  // sample path
  ////////////////////////////////////////////////////////////

  localparam int OUTPUT_WIDTH = 12;
  localparam int SCALE_BITS = 4;
  localparam real PI = 3.14159265358979;              // used to fill the cosine table

  ////////////////////////////////////////////////////////////
  // dither
  ////////////////////////////////////////////////////////////

  localparam int LFSR_BITS = 16;

  // right-shifting galois form of x^16+x^14+x^13+x^11+1
  localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 16'hb400;

  localparam logic [LANES-1:0][LFSR_BITS-1:0] LFSR_SEEDS = {
    16'h5a3c,                                         // lane 3
    16'h7b35,
    16'h1d0f,
    16'hace1                                          // lane 0
  };

  // one output word, seen either as the flat bus or lane by lane
  typedef union packed {
    logic [LANES*OUTPUT_WIDTH-1:0] flat;
    logic signed [LANES-1:0][OUTPUT_WIDTH-1:0] lanes; // lane 0 in the low bits
  } sample_word_u;

endpackage

`default_nettype wire

// ==== rtl/sample_phase_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface sample_phase_if import dds_pkg::*; ();

  logic advance;                                      // whole pipeline moves when high
  logic phase_valid;
  logic [LANES-1:0][PHASE_BITS-1:0] phase;
  logic [LANES-1:0][LFSR_BITS-1:0] dither_bits;

  modport accumulator (input advance, output phase, output phase_valid);

  modport dither (input advance, output dither_bits);

  modport lut (input advance, input phase, input phase_valid, input dither_bits);

  modport sink (output advance);

endinterface

`default_nettype wire

// ==== rtl/phase_accumulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_accumulator import dds_pkg::*; (
  input logic clk,
  input logic reset,
  input logic [PHASE_BITS-1:0] phase_inc,
  input logic phase_inc_valid,
  output logic pinc_change,
  sample_phase_if.accumulator sp
);

  logic [LANES-1:0][PHASE_BITS-1:0] lane_inc;         // lane k holds phase_inc times k+1
  logic [PHASE_BITS-1:0] word_phase;

  ////////////////////////////////////////////////////////////
  // increment load, independent of back-pressure
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      lane_inc <= '0;
      pinc_change <= 1'b0;
    end else begin
      pinc_change <= phase_inc_valid;                 // one cycle per strobe
      if (phase_inc_valid) begin
        for (int k = 0; k < LANES; k++) begin
          lane_inc[k] <= PHASE_BITS'(phase_inc * (k + 1));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 1: word phase and lane phases
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      word_phase <= '0;
      sp.phase <= '0;
      sp.phase_valid <= 1'b0;
    end else if (sp.advance) begin
      // the word steps by the full LANES multiple, lanes fan out from the old value
      word_phase <= word_phase + lane_inc[LANES-1];
      sp.phase[0] <= word_phase;
      for (int k = 1; k < LANES; k++) begin
        sp.phase[k] <= word_phase + lane_inc[k-1];
      end
      sp.phase_valid <= 1'b1;                         // constant 1 enters the valid chain
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dither_lfsr.sv ====
`timescale 1ns/1ns
`default_nettype none

module dither_lfsr import dds_pkg::*; (
  input logic clk,
  input logic reset,
  sample_phase_if.dither sp
);

  // one right shift of a galois register, taps folded in when bit 0 falls out
  function automatic logic [LFSR_BITS-1:0] galois_step(input logic [LFSR_BITS-1:0] state);
    logic [LFSR_BITS-1:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ LFSR_TAPS;
    end
    return shifted;
  endfunction

  logic [LANES-1:0][LFSR_BITS-1:0] lfsr_next;

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lfsr_next[k] = galois_step(sp.dither_bits[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sp.dither_bits <= LFSR_SEEDS;                   // every lane starts from its own seed
    end else if (sp.advance) begin
      sp.dither_bits <= lfsr_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cosine_lut.sv ====
`timescale 1ns/1ns
`default_nettype none

module cosine_lut import dds_pkg::*; (
  input logic clk,
  input logic reset,
  sample_phase_if.lut sp,
  output logic signed [OUTPUT_WIDTH-1:0] lut_sample [LANES],
  output logic lut_valid
);

  // floor(cos(2 pi a / depth) * (2^(w-1) - 0.5) - 0.5)
  function automatic logic signed [OUTPUT_WIDTH-1:0] cos_entry(input int a);
    real x;
    x = $cos(2.0 * PI * a / LUT_DEPTH) * (2.0 ** (OUTPUT_WIDTH - 1) - 0.5) - 0.5;
    return OUTPUT_WIDTH'($rtoi($floor(x)));
  endfunction

  logic signed [OUTPUT_WIDTH-1:0] cos_table [LUT_DEPTH];
  logic [LANES-1:0][PHASE_BITS-1:0] phase_dithered;
  logic [LANES-1:0][LUT_ADDR_BITS-1:0] lut_addr;
  logic [1:0] valid_pipe;                             // stage 2 and stage 3 valid

  initial begin
    for (int a = 0; a < LUT_DEPTH; a++) begin
      cos_table[a] = cos_entry(a);
    end
  end

  // dither only touches the bits that quantization throws away
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      phase_dithered[k] = sp.phase[k] + PHASE_BITS'(sp.dither_bits[k][QUANT_BITS-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lut_addr <= '0;
      valid_pipe <= '0;
      for (int k = 0; k < LANES; k++) begin
        lut_sample[k] <= '0;
      end
    end else if (sp.advance) begin
      for (int k = 0; k < LANES; k++) begin
        lut_addr[k] <= phase_dithered[k][PHASE_BITS-1:QUANT_BITS];  // stage 2
        lut_sample[k] <= cos_table[lut_addr[k]];                    // stage 3
      end
      valid_pipe <= {valid_pipe[0], sp.phase_valid};
    end
  end

  assign lut_valid = valid_pipe[1];

endmodule

`default_nettype wire

// ==== rtl/amplitude_scaler.sv ====
`timescale 1ns/1ns
`default_nettype none

module amplitude_scaler import dds_pkg::*; (
  input logic clk,
  input logic reset,
  input logic [SCALE_BITS-1:0] cos_scale,
  input logic cos_scale_valid,
  input logic signed [OUTPUT_WIDTH-1:0] lut_sample [LANES],
  input logic lut_valid,
  input logic cos_ready,
  output logic cos_valid,
  output sample_word_u cos_data,
  sample_phase_if.sink sp
);

  logic [SCALE_BITS-1:0] scale_reg;
  sample_word_u scaled_word;

  assign sp.advance = cos_ready;                      // back-pressure stalls every stage

  // scale loads on any cycle, stalled or not
  always_ff @(posedge clk) begin
    if (reset) begin
      scale_reg <= '0;
    end else if (cos_scale_valid) begin
      scale_reg <= cos_scale;
    end
  end

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      scaled_word.lanes[k] = lut_sample[k] >>> scale_reg;  // sign kept
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 4: output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cos_data <= '0;
      cos_valid <= 1'b0;
    end else if (cos_ready) begin
      cos_data <= scaled_word;
      cos_valid <= lut_valid;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dds_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dds_top import dds_pkg::*; (
  input logic clk,
  input logic reset,
  input logic [PHASE_BITS-1:0] phase_inc,
  input logic phase_inc_valid,
  input logic [SCALE_BITS-1:0] cos_scale,
  input logic cos_scale_valid,
  input logic cos_ready,
  output logic cos_valid,
  output logic [LANES*OUTPUT_WIDTH-1:0] cos_data,
  output logic pinc_change
);

  sample_phase_if sp ();

  logic signed [OUTPUT_WIDTH-1:0] lut_sample [LANES];
  logic lut_valid;
  sample_word_u cos_word;

  ////////////////////////////////////////////////////////////
  // phase and dither sources
  ////////////////////////////////////////////////////////////

  phase_accumulator u_phase_accumulator (
    .clk(clk),
    .reset(reset),
    .phase_inc(phase_inc),
    .phase_inc_valid(phase_inc_valid),
    .pinc_change(pinc_change),
    .sp(sp.accumulator)
  );

  dither_lfsr u_dither_lfsr (
    .clk(clk),
    .reset(reset),
    .sp(sp.dither)
  );

  ////////////////////////////////////////////////////////////
  // table lookup and output stage
  ////////////////////////////////////////////////////////////

  cosine_lut u_cosine_lut (
    .clk(clk),
    .reset(reset),
    .sp(sp.lut),
    .lut_sample(lut_sample),
    .lut_valid(lut_valid)
  );

  amplitude_scaler u_amplitude_scaler (
    .clk(clk),
    .reset(reset),
    .cos_scale(cos_scale),
    .cos_scale_valid(cos_scale_valid),
    .lut_sample(lut_sample),
    .lut_valid(lut_valid),
    .cos_ready(cos_ready),
    .cos_valid(cos_valid),
    .cos_data(cos_word),
    .sp(sp.sink)
  );

  assign cos_data = cos_word.flat;                    // lane 0 in the low bits

endmodule

`default_nettype wire

// ==== bench/dds_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module dds_checker import dds_pkg::*; (
  input logic clk,
  input logic reset,
  input logic phase_inc_valid,
  input logic pinc_change,
  input logic cos_ready,
  input logic cos_valid,
  input logic [LANES*OUTPUT_WIDTH-1:0] cos_data
);

  valid_low_in_reset: assert property (@(posedge clk) reset |=> !cos_valid)
    else $error("cos_valid is high after a reset cycle");

  pinc_follows_strobe: assert property (
    @(posedge clk) disable iff (reset) phase_inc_valid |=> pinc_change
  ) else $error("pinc_change missing after a phase_inc_valid strobe");

  // a pulse without a strobe in the cycle before would mean a stretched pulse
  pinc_single_cycle: assert property (
    @(posedge clk) disable iff (reset) !phase_inc_valid |=> !pinc_change
  ) else $error("pinc_change high without a strobe the cycle before");

  held_output_stable: assert property (
    @(posedge clk) disable iff (reset)
    cos_valid && !cos_ready |=> $stable(cos_data) && $stable(cos_valid)
  ) else $error("output word changed while it was held by cos_ready");

endmodule

bind dds_top dds_checker u_dds_checker (
  .clk(clk),
  .reset(reset),
  .phase_inc_valid(phase_inc_valid),
  .pinc_change(pinc_change),
  .cos_ready(cos_ready),
  .cos_valid(cos_valid),
  .cos_data(cos_data)
);

`default_nettype wire

// ==== bench/dds_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dds_tb import dds_pkg::*; ();

  logic clk;
  logic reset;
  logic [PHASE_BITS-1:0] phase_inc;
  logic phase_inc_valid;
  logic [SCALE_BITS-1:0] cos_scale;
  logic cos_scale_valid;
  logic cos_ready;
  logic cos_valid;
  logic [LANES*OUTPUT_WIDTH-1:0] cos_data;
  logic pinc_change;

  logic [PHASE_BITS-1:0] test_inc [$];
  int test_scale [$];
  int test_words [$];
  int test_stall [$];
  int test_pulses [$];

  // reference pipeline with one register set per stage
  logic signed [OUTPUT_WIDTH-1:0] ref_table [LUT_DEPTH];
  logic [PHASE_BITS-1:0] m_word_phase;
  logic [PHASE_BITS-1:0] m_lane_inc [LANES];
  logic [PHASE_BITS-1:0] m_phase [LANES];
  logic [LFSR_BITS-1:0] m_lfsr [LANES];
  logic [LUT_ADDR_BITS-1:0] m_addr [LANES];
  logic signed [OUTPUT_WIDTH-1:0] m_sample [LANES];
  logic [SCALE_BITS-1:0] m_scale;
  logic [3:0] m_valid;                                // stage 1 in bit 0 up to cos_valid in bit 3
  logic m_pinc;
  sample_word_u m_out;

  int error_count;
  int word_count;
  int pulse_count;
  int total_words;
  int cycle_count;
  int cycle_limit;

  dds_top DUT (
    .clk(clk),
    .reset(reset),
    .phase_inc(phase_inc),
    .phase_inc_valid(phase_inc_valid),
    .cos_scale(cos_scale),
    .cos_scale_valid(cos_scale_valid),
    .cos_ready(cos_ready),
    .cos_valid(cos_valid),
    .cos_data(cos_data),
    .pinc_change(pinc_change)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic signed [OUTPUT_WIDTH-1:0] table_value(input int a);
    real angle;
    real amp;
    angle = 2.0 * PI * a / LUT_DEPTH;
    amp = 2.0 ** (OUTPUT_WIDTH - 1) - 0.5;
    return OUTPUT_WIDTH'($rtoi($floor($cos(angle) * amp - 0.5)));
  endfunction

  function automatic logic [LFSR_BITS-1:0] lfsr_next(input logic [LFSR_BITS-1:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic reset_model();
    m_word_phase = '0;
    m_scale = '0;
    m_valid = '0;
    m_pinc = 1'b0;
    m_out = '0;
    for (int k = 0; k < LANES; k++) begin
      m_lane_inc[k] = '0;
      m_phase[k] = '0;
      m_lfsr[k] = LFSR_SEEDS[k];
      m_addr[k] = '0;
      m_sample[k] = '0;
    end
  endtask

  // advances the model over the coming edge with the inputs now on the pins
  task automatic step_model();
    logic [PHASE_BITS-1:0] dithered;
    if (cos_ready) begin
      for (int k = 0; k < LANES; k++) begin
        m_out.lanes[k] = m_sample[k] >>> m_scale;     // arithmetic shift keeps the sign
        m_sample[k] = ref_table[m_addr[k]];
        dithered = m_phase[k] + PHASE_BITS'(m_lfsr[k][QUANT_BITS-1:0]);
        m_addr[k] = dithered[PHASE_BITS-1:QUANT_BITS];
        m_lfsr[k] = lfsr_next(m_lfsr[k]);
      end
      m_phase[0] = m_word_phase;
      for (int k = 1; k < LANES; k++) begin
        m_phase[k] = m_word_phase + m_lane_inc[k-1];
      end
      m_word_phase = m_word_phase + m_lane_inc[LANES-1];
      m_valid = {m_valid[2:0], 1'b1};
    end
    m_pinc = phase_inc_valid;
    if (phase_inc_valid) begin
      for (int k = 0; k < LANES; k++) begin
        m_lane_inc[k] = PHASE_BITS'(phase_inc * (k + 1));
      end
    end
    if (cos_scale_valid) begin
      m_scale = cos_scale;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input sample_word_u expected, input sample_word_u actual);
    for (int k = 0; k < LANES; k++) begin
      if (actual.lanes[k] !== expected.lanes[k]) begin
        $display("FAILED cos_data lane %0d: expected %h actual %h",
                 k, expected.lanes[k], actual.lanes[k]);
        error_count++;
      end
    end
  endtask

  task automatic check_pulse(input int expected, input int actual);
    if (actual != expected) begin
      $display("FAILED pinc_change pulses: expected %h actual %h", expected, actual);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic compare_outputs();
    sample_word_u actual;
    actual.flat = cos_data;
    check_flag("cos_valid", m_valid[3], cos_valid);
    check_flag("pinc_change", m_pinc, pinc_change);
    if (pinc_change) begin
      pulse_count++;
    end
    if (cos_valid) begin                              // a stalled word is checked on every held cycle
      check_word(m_out, actual);
    end
    if (cos_valid && cos_ready) begin                 // a word moves on the coming edge
      word_count++;
      total_words++;
    end
  endtask

  task automatic drive_cycle(input logic [PHASE_BITS-1:0] inc, input logic inc_strobe,
                             input int scale, input logic scale_strobe, input int stall_pct);
    @(posedge clk);
    #2;
    phase_inc = inc;
    phase_inc_valid = inc_strobe;
    cos_scale = SCALE_BITS'(scale);
    cos_scale_valid = scale_strobe;
    cos_ready = (int'($urandom % 100) >= stall_pct);
    @(negedge clk);
    compare_outputs();
    step_model();
  endtask

  task automatic read_stim();
    int fd;
    int n;
    string line;
    logic [PHASE_BITS-1:0] inc;
    int scale;
    int words;
    int stall;
    int pulses;
    fd = $fopen("bench/dds_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/dds_stim.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %d %d %d %d", inc, scale, words, stall, pulses);
        if (n == 5) begin
          test_inc.push_back(inc);
          test_scale.push_back(scale);
          test_words.push_back(words);
          test_stall.push_back(stall);
          test_pulses.push_back(pulses);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int idx);
    int errors_before;
    logic inc_strobe;
    errors_before = error_count;
    word_count = 0;
    pulse_count = 0;
    inc_strobe = (test_inc[idx] != phase_inc);        // an unchanged increment is not reloaded
    drive_cycle(test_inc[idx], inc_strobe, test_scale[idx], 1'b1, test_stall[idx]);
    while (word_count < test_words[idx]) begin
      drive_cycle(test_inc[idx], 1'b0, test_scale[idx], 1'b0, test_stall[idx]);
    end
    check_pulse(test_pulses[idx], pulse_count);
    $display("test %0d: inc %h scale %0d words %0d stall %0d%% pulses %0d, %0d errors",
             idx, test_inc[idx], test_scale[idx], word_count, test_stall[idx],
             pulse_count, error_count - errors_before);
  endtask

  initial begin
    void'($urandom(32'h2e7d_7b68));
    reset = 1'b1;
    phase_inc = '0;
    phase_inc_valid = 1'b0;
    cos_scale = '0;
    cos_scale_valid = 1'b0;
    cos_ready = 1'b0;
    error_count = 0;
    total_words = 0;
    cycle_count = 0;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      ref_table[a] = table_value(a);
    end
    reset_model();
    read_stim();
    if (test_inc.size() == 0) begin
      $display("no tests were read from the stimulus file");
      error_count++;
    end
    cycle_limit = 100;
    foreach (test_words[i]) begin
      cycle_limit += 4 * test_words[i];
    end
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    compare_outputs();
    step_model();
    for (int i = 0; i < test_inc.size(); i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d words, %0d cycles, %0d errors",
             test_inc.size(), total_words, cycle_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dds.f ====
rtl/dds_pkg.sv
rtl/sample_phase_if.sv
rtl/phase_accumulator.sv
rtl/dither_lfsr.sv
rtl/cosine_lut.sv
rtl/amplitude_scaler.sv
rtl/dds_top.sv
bench/dds_checker.sv
bench/dds_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dds_tb
RTL_TOP ?= dds_top
FILELIST ?= dds.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
RTL_SRCS ?= rtl/dds_pkg.sv rtl/sample_phase_if.sv rtl/phase_accumulator.sv \
            rtl/dither_lfsr.sv rtl/cosine_lut.sv rtl/amplitude_scaler.sv rtl/dds_top.sv
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/dds_stim.txt ====
# increment(hex) scale words stall_percent expected_pinc_pulses
# the increment is strobed only when it differs from the one already loaded
0000 0 16 0 0
0123 0 40 0 1
3a17 1 40 0 1
3a17 2 24 30 0
0400 3 32 50 1
ffff 4 24 20 1
8001 5 24 0 1
8001 6 24 40 0
1000 7 24 10 1
0d2b 8 24 50 1
0d2b 9 16 25 0
7fff 10 16 0 1
0001 11 16 35 1
2222 12 16 0 1
2222 13 16 50 0
5c29 14 16 20 1
0123 15 24 30 1
0123 0 16 0 0
